/* flist.f */
hw/e4_state_pkg.sv
hw/e4_io_pkg.sv
hw/e4_control.sv
hw/e4_cmd_encoder.sv
hw/e4_top.sv
verification/e4_clk_gen.sv
verification/e4_props.sv
verification/e4_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module e4_tb -f flist.f -o e4_sim \
	&& ./obj_dir/e4_sim | tee /dev/stderr | grep -q "RESULT: PASS" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* verification/e4_stimulus.txt */
// in_valid cond care_mask expected_cmd expected_next_state, all hex
// cond bits outside the care mask get random data
0 00000000 00000000 000000 01 // idle after reset
1 00000407 00600E1F 000000 01 // s1 silent self-loop
1 00400A00 00600E1F 000003 02 // s1 -> s2
1 00040000 02040010 080060 0B // s2 -> s11
1 00000000 0010408B 000017 08 // s11 -> s8
1 00000000 2010228D 020400 09
1 02800040 0A800040 000114 14 // s9 -> s20
1 00000000 00004041 001040 18 // s20 -> s24
1 00000000 00000000 020400 09 // s24 always back to s9
0 00000000 00000000 000000 09 // no valid word
0 00000000 00000000 000000 09
1 00000000 0A800040 000000 01 // s9 -> s1 silent
1 00400A00 00600E1F 000003 02
1 00000000 02040010 000440 0E // s2 -> s14 short form
1 00000001 00004001 000170 0E // s14 self-loop, long form
1 00004000 00004001 020400 09
1 00000000 0A800040 000000 01
1 00000003 00600E1F 001100 03 // s1 -> s3
1 08040001 08044001 000170 0E // s3 -> s14 long form
1 00000000 00004001 000001 0A // s14 -> s10
1 00041000 00161800 002400 10 // s10 -> s16
1 00000100 00000104 001000 17 // s16 -> s23, pass 1
1 00001000 00081000 A08000 04 // s23 -> s4
1 00000010 220487B4 002400 10 // s4 -> s16
1 00000100 00000104 001000 17 // pass 2
0 00000000 00000000 000000 17 // stall in s23
1 00001000 00081000 A08000 04
1 00000010 220487B4 002400 10
1 00000100 00000104 001000 17 // pass 3
1 00001000 00081000 A08000 04
1 00000010 220487B4 002400 10
1 00000100 00000104 001000 17 // pass 4
1 00001000 00081000 A08000 04
1 00000010 220487B4 002400 10
1 00000100 00000104 001000 17 // pass 5
1 00001000 00081000 A08000 04
1 00000010 220487B4 002400 10
1 00000100 00000104 001000 17 // pass 6
1 00080000 00081000 202000 11 // s23 -> s17
1 00200000 40281002 000000 01 // s17 -> s1 silent
FF 00000000 00000000 000000 00 // end of vectors

/* verification/e4_tb.sv */
`timescale 1ns/1ps

module e4_tb;

	localparam int mem_depth = 512;
	localparam int max_vectors = 100;
	localparam int fields = 5; // in_valid, cond, mask, cmd, next state
	localparam int reset_cycles = 10;
	localparam int reset_timeout = 40; // cycles
	localparam logic [31:0] end_marker = 32'hFF;

	logic                 rst;
	logic                 clk;
	logic                 in_valid;
	e4_io_pkg::cond_t     cond;
	e4_io_pkg::cmd_t      cmd;
	e4_state_pkg::state_t state;

	logic [31:0] vec_mem [0:mem_depth-1];
	logic [31:0] rng_state;

	e4_clk_gen clk_gen_i
	(
		.rst (rst)
	);

	e4_top dut_i
	(
		.rst      (rst),
		.clk      (clk),
		.in_valid (in_valid),
		.cond     (cond),
		.cmd      (cmd),
		.state    (state)
	);

	//////////////////////////////////////////////////
	// helpers

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic fail_now(input string what);
		$display("%s", what);
		$display("RESULT: FAIL");
		$fatal(1, "%s", what);
	endtask

	task automatic check_value
	(
		input string       name,
		input logic [31:0] expected,
		input logic [31:0] actual
	);
		if (actual !== expected)
		begin
			$display("ERROR %s expected %h actual %h", name, expected, actual);
			fail_now("simulation stopped on a mismatch");
		end
	endtask

	//////////////////////////////////////////////////
	// reset is active low on clk

	initial
	begin
		clk = 1'b0;
		repeat (reset_cycles) @(posedge rst);
		#2;
		clk = 1'b1;
	end

	//////////////////////////////////////////////////
	// vector loop

	initial
	begin
		int          i;
		int          waited;
		logic [8:0]  addr;
		logic [31:0] mask;
		logic [31:0] drive;
		logic        done;

		in_valid = 1'b0;
		cond = '0;
		rng_state = 32'h5443;
		$readmemh("verification/e4_stimulus.txt", vec_mem);

		waited = 0;
		while (clk !== 1'b1)
		begin
			@(posedge rst);
			waited++;
			if (waited > reset_timeout)
				fail_now("reset was never released");
		end
		#1;
		check_value("reset state", 32'(e4_state_pkg::st_s1), 32'(state));
		#1; // inputs change 2 ns after the edge

		i = 0;
		done = 1'b0;
		while (!done && i < max_vectors)
		begin
			addr = 9'(i * fields);
			if (vec_mem[addr] === end_marker)
				done = 1'b1;
			else
			begin
				rng_state = xorshift(rng_state);
				mask = vec_mem[addr + 9'd2];
				drive = (vec_mem[addr + 9'd1] & mask) | (rng_state & ~mask);
				in_valid = vec_mem[addr][0];
				cond = drive[e4_io_pkg::cond_width-1:0];
				#28;
				check_value($sformatf("vector %0d cmd", i), vec_mem[addr + 9'd3], 32'(cmd));
				@(posedge rst);
				#1;
				check_value($sformatf("vector %0d state", i), vec_mem[addr + 9'd4],
					32'(state));
				#1;
				i++;
			end
		end

		if (done && i > 0)
		begin
			$display("RESULT: PASS");
			$finish;
		end
		else
			fail_now("stimulus file has no vectors or no end marker");
	end

endmodule

/* verification/e4_props.sv */
`timescale 1ns/1ps

module e4_props
(
	input logic                 rst,
	input logic                 clk,
	input logic                 in_valid,
	input e4_io_pkg::cmd_t      cmd,
	input e4_state_pkg::state_t state
);

	// commands only on valid words
	cmd_quiet: assert property (@(posedge rst) disable iff (!clk)
		!in_valid |-> cmd == '0)
		else $error("command driven while in_valid is low");

	state_hold: assert property (@(posedge rst) disable iff (!clk)
		!in_valid |=> $stable(state))
		else $error("state changed while in_valid is low");

	// first edge after release
	reset_state: assert property (@(posedge rst)
		$rose(clk) |-> state == e4_state_pkg::st_s1)
		else $error("state is not s1 after reset release");

endmodule

bind e4_top e4_props props_i
(
	.rst      (rst),
	.clk      (clk),
	.in_valid (in_valid),
	.cmd      (cmd),
	.state    (state)
);

/* verification/e4_clk_gen.sv */
`timescale 1ns/1ps

module e4_clk_gen
(
	output logic rst // the design clock
);

	localparam int half_period = 20; // 40 ns period

	initial
	begin
		rst = 1'b0;
		forever
		begin
			#half_period;
			rst = ~rst;
		end
	end

endmodule

/* hw/e4_top.sv */
`timescale 1ns/1ps

module e4_top
(
	input  logic                 rst,      // clock
	input  logic                 clk,      // async reset, active low
	input  logic                 in_valid,
	input  e4_io_pkg::cond_t     cond,
	output e4_io_pkg::cmd_t      cmd,
	output e4_state_pkg::state_t state
);

	e4_state_pkg::action_t action;

	// mealy path: cond -> action -> cmd in the same cycle
	e4_control control_i
	(
		.rst      (rst),
		.clk      (clk),
		.in_valid (in_valid),
		.cond     (cond),
		.state    (state),
		.action   (action)
	);

	e4_cmd_encoder encoder_i
	(
		.action (action),
		.cmd    (cmd)
	);

endmodule

/* hw/e4_cmd_encoder.sv */
`timescale 1ns/1ps

module e4_cmd_encoder
(
	input  e4_state_pkg::action_t action,
	output e4_io_pkg::cmd_t       cmd
);

	//////////////////////////////////////////////////
	// action code to command word, bit n-1 is yn

	always_comb
	begin
		case (action)
			e4_state_pkg::act_s2:        cmd = 24'h000003; // y1 y2
			e4_state_pkg::act_s3:        cmd = 24'h001100; // y9 y13
			e4_state_pkg::act_s4:        cmd = 24'hA08000; // y16 y22 y24
			e4_state_pkg::act_s5:        cmd = 24'h000005; // y1 y3
			e4_state_pkg::act_s6:        cmd = 24'h090000; // y17 y20
			e4_state_pkg::act_s7:        cmd = 24'h000A80; // y8 y10 y12
			e4_state_pkg::act_s8:        cmd = 24'h000017; // y1 y2 y3 y5
			e4_state_pkg::act_s9:        cmd = 24'h020400; // y11 y18
			e4_state_pkg::act_s10:       cmd = 24'h000001; // y1
			e4_state_pkg::act_s11:       cmd = 24'h080060; // y6 y7 y20
			e4_state_pkg::act_s12:       cmd = 24'hA04000; // y15 y22 y24
			e4_state_pkg::act_s13:       cmd = 24'h180002; // y2 y20 y21

			// s14 is reached from s2 with the short form,
			// from s3, s11, s20, s22 and itself with the long one
			e4_state_pkg::act_s14_short: cmd = 24'h000440; // y7 y11
			e4_state_pkg::act_s14_long:  cmd = 24'h000170; // y5 y6 y7 y9

			e4_state_pkg::act_s15:       cmd = 24'h001030; // y5 y6 y13
			e4_state_pkg::act_s16:       cmd = 24'h002400; // y11 y14
			e4_state_pkg::act_s17:       cmd = 24'h202000; // y14 y22
			e4_state_pkg::act_s18:       cmd = 24'h000098; // y4 y5 y8
			e4_state_pkg::act_s19:       cmd = 24'h400400; // y11 y23
			e4_state_pkg::act_s20:       cmd = 24'h000114; // y3 y5 y9
			e4_state_pkg::act_s21:       cmd = 24'h2C0800; // y12 y19 y20 y22
			e4_state_pkg::act_s22:       cmd = 24'h001440; // y7 y11 y13
			e4_state_pkg::act_s23:       cmd = 24'h001000; // y13
			e4_state_pkg::act_s24:       cmd = 24'h001040; // y7 y13

			// act_none and unused codes
			default:                     cmd = '0;
		endcase
	end

endmodule

/* hw/e4_control.sv */
`timescale 1ns/1ps

module e4_control
(
	input  logic                  rst,
	input  logic                  clk,
	input  logic                  in_valid,
	input  e4_io_pkg::cond_t      cond,
	output e4_state_pkg::state_t  state,
	output e4_state_pkg::action_t action
);

	typedef struct packed
	{
		e4_state_pkg::state_t  nxt;
		e4_state_pkg::action_t act;
	} step_t;

	step_t step;

	//////////////////////////////////////////////////
	// shared exit branches

	function automatic step_t go
	(
		input e4_state_pkg::state_t  s,
		input e4_state_pkg::action_t a
	);
		step_t r;
		r.nxt = s;
		r.act = a;
		return r;
	endfunction

	// exits of s2, also the x08 leg of the s15 group
	function automatic step_t from_s2(input e4_io_pkg::cond_t c);
		if (c.x19) return go(e4_state_pkg::st_s11, e4_state_pkg::act_s11);
		else if (!c.x26) return go(e4_state_pkg::st_s14, e4_state_pkg::act_s14_short);
		else if (c.x05) return go(e4_state_pkg::st_s12, e4_state_pkg::act_s12);
		else return go(e4_state_pkg::st_s13, e4_state_pkg::act_s13);
	endfunction

	// s14 exits, also taken from s3 and s11
	function automatic step_t from_s14(input e4_io_pkg::cond_t c);
		if (c.x01) return go(e4_state_pkg::st_s14, e4_state_pkg::act_s14_long);
		else if (c.x15) return go(e4_state_pkg::st_s9, e4_state_pkg::act_s9);
		else return go(e4_state_pkg::st_s10, e4_state_pkg::act_s10);
	endfunction

	// s15 exits, s4 takes the same branch when x30 is set
	function automatic step_t from_s15(input e4_io_pkg::cond_t c);
		if (!c.x16 && c.x10) return go(e4_state_pkg::st_s9, e4_state_pkg::act_s9);
		else if (!c.x16) return go(e4_state_pkg::st_s1, e4_state_pkg::act_none);
		else if (c.x06) return go(e4_state_pkg::st_s15, e4_state_pkg::act_s15);
		else if (!c.x08) return go(e4_state_pkg::st_s1, e4_state_pkg::act_none);
		else return from_s2(c);
	endfunction

	// x20 / x13 split shared by s6, s12, s17 and s23
	function automatic step_t from_s23(input e4_io_pkg::cond_t c);
		if (c.x20) return go(e4_state_pkg::st_s17, e4_state_pkg::act_s17);
		else if (c.x13) return go(e4_state_pkg::st_s4, e4_state_pkg::act_s4);
		else return go(e4_state_pkg::st_s9, e4_state_pkg::act_s9);
	endfunction

	//////////////////////////////////////////////////
	// transition table, first matching row wins

	always_comb
	begin
		case (state)
			e4_state_pkg::st_s1:
			begin
				if (cond.x10)
				begin
					if (!cond.x12) step = go(e4_state_pkg::st_s6, e4_state_pkg::act_s6);
					else if (cond.x23) step = go(e4_state_pkg::st_s2, e4_state_pkg::act_s2);
					else if (cond.x04) step = go(e4_state_pkg::st_s3, e4_state_pkg::act_s3);
					else step = go(e4_state_pkg::st_s4, e4_state_pkg::act_s4);
				end
				else if (!cond.x01)
				begin
					if (cond.x11 && !cond.x04) step = go(e4_state_pkg::st_s8, e4_state_pkg::act_s8);
					else step = go(e4_state_pkg::st_s4, e4_state_pkg::act_s4);
				end
				else if (cond.x22) step = go(e4_state_pkg::st_s7, e4_state_pkg::act_s7);
				else if (!cond.x02) step = go(e4_state_pkg::st_s5, e4_state_pkg::act_s5);
				else if (cond.x03 && cond.x11) step = go(e4_state_pkg::st_s1, e4_state_pkg::act_none);
				else if (cond.x03) step = go(e4_state_pkg::st_s8, e4_state_pkg::act_s8);
				else if (!cond.x11) step = go(e4_state_pkg::st_s3, e4_state_pkg::act_s3);
				else if (cond.x05) step = go(e4_state_pkg::st_s9, e4_state_pkg::act_s9);
				else step = go(e4_state_pkg::st_s10, e4_state_pkg::act_s10);
			end
			e4_state_pkg::st_s2: step = from_s2(cond);
			e4_state_pkg::st_s3:
			begin
				if (!cond.x19) step = go(e4_state_pkg::st_s10, e4_state_pkg::act_s10);
				else if (!cond.x28) step = go(e4_state_pkg::st_s8, e4_state_pkg::act_s8);
				else step = from_s14(cond);
			end
			e4_state_pkg::st_s4:
			begin
				if (cond.x30) step = from_s15(cond);
				else if (cond.x05 && cond.x09) step = go(e4_state_pkg::st_s1, e4_state_pkg::act_none);
				else if (cond.x05) step = go(e4_state_pkg::st_s16, e4_state_pkg::act_s16);
				else if (cond.x03 && cond.x11) step = go(e4_state_pkg::st_s4, e4_state_pkg::act_none);
				else if (cond.x03) step = go(e4_state_pkg::st_s8, e4_state_pkg::act_s8);
				else if (cond.x11) step = go(e4_state_pkg::st_s10, e4_state_pkg::act_s10);
				else step = go(e4_state_pkg::st_s3, e4_state_pkg::act_s3);
			end
			e4_state_pkg::st_s5:
			begin
				if (!cond.x11) step = go(e4_state_pkg::st_s3, e4_state_pkg::act_s3);
				else if (!cond.x25) step = go(e4_state_pkg::st_s10, e4_state_pkg::act_s10);
				else if (cond.x03) step = go(e4_state_pkg::st_s3, e4_state_pkg::act_s3);
				else if (cond.x05) step = go(e4_state_pkg::st_s4, e4_state_pkg::act_s4);
				else step = go(e4_state_pkg::st_s5, e4_state_pkg::act_none); // silent self-loop
			end
			e4_state_pkg::st_s6:
			begin
				if (!cond.x12 && cond.x29) step = go(e4_state_pkg::st_s11, e4_state_pkg::act_s11);
				else if (!cond.x12) step = go(e4_state_pkg::st_s21, e4_state_pkg::act_s21);
				else if (cond.x27) step = from_s23(cond);
				else if (cond.x29 && cond.x01) step = go(e4_state_pkg::st_s18, e4_state_pkg::act_s18);
				else if (cond.x29) step = go(e4_state_pkg::st_s8, e4_state_pkg::act_s8);
				else if (cond.x02) step = go(e4_state_pkg::st_s11, e4_state_pkg::act_s11);
				else step = go(e4_state_pkg::st_s20, e4_state_pkg::act_s20);
			end
			e4_state_pkg::st_s7:
			begin
				if (cond.x02) step = go(e4_state_pkg::st_s4, e4_state_pkg::act_s4);
				else step = go(e4_state_pkg::st_s19, e4_state_pkg::act_s19);
			end
			e4_state_pkg::st_s8:
			begin
				if (!cond.x14 && cond.x03 && cond.x21)
					step = go(e4_state_pkg::st_s13, e4_state_pkg::act_s13);
				else if (!cond.x14) step = go(e4_state_pkg::st_s9, e4_state_pkg::act_s9);
				else if (cond.x08 && cond.x10) step = go(e4_state_pkg::st_s9, e4_state_pkg::act_s9);
				else if (cond.x08) step = go(e4_state_pkg::st_s1, e4_state_pkg::act_none);
				else if (!cond.x30) step = go(e4_state_pkg::st_s9, e4_state_pkg::act_s9);
				else if (cond.x01) step = go(e4_state_pkg::st_s18, e4_state_pkg::act_s18);
				else if (cond.x04) step = go(e4_state_pkg::st_s12, e4_state_pkg::act_s12);
				else step = go(e4_state_pkg::st_s19, e4_state_pkg::act_s19);
			end
			e4_state_pkg::st_s9:
			begin
				if (!cond.x24 && cond.x28) step = go(e4_state_pkg::st_s6, e4_state_pkg::act_s6);
				else if (!cond.x24) step = go(e4_state_pkg::st_s1, e4_state_pkg::act_none);
				else if (!cond.x26) step = go(e4_state_pkg::st_s19, e4_state_pkg::act_s19);
				else if (cond.x07) step = go(e4_state_pkg::st_s20, e4_state_pkg::act_s20);
				else step = go(e4_state_pkg::st_s22, e4_state_pkg::act_s22);
			end
			e4_state_pkg::st_s10:
			begin
				if (!cond.x19) step = go(e4_state_pkg::st_s1, e4_state_pkg::act_none);
				else if (cond.x13) step = go(e4_state_pkg::st_s16, e4_state_pkg::act_s16);
				else if (!cond.x21) step = go(e4_state_pkg::st_s9, e4_state_pkg::act_s9);
				else if (!cond.x18) step = go(e4_state_pkg::st_s8, e4_state_pkg::act_s8);
				else if (cond.x12) step = go(e4_state_pkg::st_s10, e4_state_pkg::act_none);
				else step = go(e4_state_pkg::st_s19, e4_state_pkg::act_s19);
			end
			e4_state_pkg::st_s11:
			begin
				if (!cond.x02) step = go(e4_state_pkg::st_s8, e4_state_pkg::act_s8);
				else if (cond.x08) step = from_s14(cond);
				else if (!cond.x21) step = go(e4_state_pkg::st_s10, e4_state_pkg::act_s10);
				else if (cond.x01) step = go(e4_state_pkg::st_s18, e4_state_pkg::act_s18);
				else if (cond.x04) step = go(e4_state_pkg::st_s12, e4_state_pkg::act_s12);
				else step = go(e4_state_pkg::st_s19, e4_state_pkg::act_s19);
			end
			e4_state_pkg::st_s12:
			begin
				if (!cond.x16) step = go(e4_state_pkg::st_s1, e4_state_pkg::act_none);
				else if (cond.x19) step = from_s23(cond);
				else if (!cond.x30 && cond.x08) step = go(e4_state_pkg::st_s17, e4_state_pkg::act_s17);
				else if (!cond.x30) step = go(e4_state_pkg::st_s1, e4_state_pkg::act_none);
				else if (!cond.x26 && cond.x03) step = go(e4_state_pkg::st_s17, e4_state_pkg::act_s17);
				else if (cond.x01) step = go(e4_state_pkg::st_s18, e4_state_pkg::act_s18);
				else step = go(e4_state_pkg::st_s8, e4_state_pkg::act_s8);
			end
			e4_state_pkg::st_s13:
			begin
				if (cond.x10) step = go(e4_state_pkg::st_s19, e4_state_pkg::act_s19);
				else if (cond.x25) step = go(e4_state_pkg::st_s20, e4_state_pkg::act_s20);
				else step = go(e4_state_pkg::st_s21, e4_state_pkg::act_s21);
			end
			e4_state_pkg::st_s14: step = from_s14(cond);
			e4_state_pkg::st_s15: step = from_s15(cond);
			e4_state_pkg::st_s16:
			begin
				if (cond.x09) step = go(e4_state_pkg::st_s23, e4_state_pkg::act_s23);
				else if (cond.x03) step = go(e4_state_pkg::st_s4, e4_state_pkg::act_s4);
				else step = go(e4_state_pkg::st_s12, e4_state_pkg::act_s12);
			end
			e4_state_pkg::st_s17:
			begin
				if (cond.x22 && cond.x02) step = from_s23(cond);
				else if (cond.x22 || cond.x31) step = go(e4_state_pkg::st_s1, e4_state_pkg::act_none);
				else step = go(e4_state_pkg::st_s4, e4_state_pkg::act_s4);
			end
			e4_state_pkg::st_s18:
			begin
				if (cond.x05) step = go(e4_state_pkg::st_s8, e4_state_pkg::act_s8);
				else if (cond.x17) step = go(e4_state_pkg::st_s12, e4_state_pkg::act_s12);
				else step = go(e4_state_pkg::st_s17, e4_state_pkg::act_s17);
			end
			e4_state_pkg::st_s19:
			begin
				if (!cond.x25 && cond.x29) step = go(e4_state_pkg::st_s7, e4_state_pkg::act_s7);
				else if (!cond.x25) step = go(e4_state_pkg::st_s18, e4_state_pkg::act_s18);
				else if (!cond.x22 && !cond.x06) step = go(e4_state_pkg::st_s13, e4_state_pkg::act_s13);
				else if (!cond.x22 && cond.x08) step = go(e4_state_pkg::st_s17, e4_state_pkg::act_s17);
				else step = go(e4_state_pkg::st_s1, e4_state_pkg::act_none);
			end
			e4_state_pkg::st_s20:
			begin
				if (!cond.x07) step = go(e4_state_pkg::st_s24, e4_state_pkg::act_s24);
				else if (cond.x15 && cond.x01) step = go(e4_state_pkg::st_s14, e4_state_pkg::act_s14_long);
				else step = go(e4_state_pkg::st_s9, e4_state_pkg::act_s9);
			end
			e4_state_pkg::st_s21:
			begin
				if (cond.x04) step = go(e4_state_pkg::st_s8, e4_state_pkg::act_s8);
				else step = go(e4_state_pkg::st_s11, e4_state_pkg::act_s11);
			end
			e4_state_pkg::st_s22:
			begin
				if (!cond.x16) step = go(e4_state_pkg::st_s6, e4_state_pkg::act_s6);
				else if (cond.x09) step = go(e4_state_pkg::st_s15, e4_state_pkg::act_s15);
				else step = go(e4_state_pkg::st_s14, e4_state_pkg::act_s14_long);
			end
			e4_state_pkg::st_s23: step = from_s23(cond);
			e4_state_pkg::st_s24: step = go(e4_state_pkg::st_s9, e4_state_pkg::act_s9); // always leaves
			default: step = go(e4_state_pkg::st_s1, e4_state_pkg::act_none);
		endcase

		// no valid word: hold and stay silent
		if (!in_valid)
			step = go(state, e4_state_pkg::act_none);
	end

	//////////////////////////////////////////////////
	// state register

	always_ff @(posedge rst or negedge clk)
	begin
		if (!clk)
			state <= e4_state_pkg::st_s1;
		else
			state <= step.nxt;
	end

	assign action = step.act;

endmodule

/* hw/e4_io_pkg.sv */
package e4_io_pkg;

	localparam int cond_width = 31;
	localparam int cmd_width = 24;

	// one bit per condition input, x31 is the msb
	typedef struct packed
	{
		logic x31;
		logic x30;
		logic x29;
		logic x28;
		logic x27;
		logic x26;
		logic x25;
		logic x24;
		logic x23;
		logic x22;
		logic x21;
		logic x20;
		logic x19;
		logic x18;
		logic x17;
		logic x16;
		logic x15;
		logic x14;
		logic x13;
		logic x12;
		logic x11;
		logic x10;
		logic x09;
		logic x08;
		logic x07;
		logic x06;
		logic x05;
		logic x04;
		logic x03;
		logic x02;
		logic x01;
	} cond_t;

	typedef logic [cmd_width-1:0] cmd_t; // bit n-1 drives yn

endpackage

/* hw/e4_state_pkg.sv */
package e4_state_pkg;

	//////////////////////////////////////////////////
	// controller states

	localparam int num_states = 24;
	localparam int state_width = $clog2(num_states + 1); // codes start at 1

	typedef enum logic [state_width-1:0]
	{
		st_s1 = 1, st_s2, st_s3, st_s4, st_s5, st_s6,
		st_s7, st_s8, st_s9, st_s10, st_s11, st_s12,
		st_s13, st_s14, st_s15, st_s16, st_s17, st_s18,
		st_s19, st_s20, st_s21, st_s22, st_s23, st_s24
	} state_t;

	//////////////////////////////////////////////////
	// action codes, one per fixed command pattern

	localparam int action_width = 5;

	// act_sN is the pattern driven when entering sN
	// s14 is entered with two different patterns
	typedef enum logic [action_width-1:0]
	{
		act_none = 0,
		act_s2, act_s3, act_s4, act_s5, act_s6, act_s7,
		act_s8, act_s9, act_s10, act_s11, act_s12, act_s13,
		act_s14_short, // y7 y11
		act_s14_long,  // y5 y6 y7 y9
		act_s15, act_s16, act_s17, act_s18, act_s19, act_s20,
		act_s21, act_s22, act_s23, act_s24
	} action_t;

endpackage
